/* include/nes_config.svh */
`ifndef NES_CONFIG_SVH
`define NES_CONFIG_SVH

// bus and datapath widths
`define NES_APB_ADDR_W      8
`define NES_APB_DATA_W      8
`define NES_GPIO_W          8
`define NES_PWM_W           8

// address bit that splits GPIO (0) from audio (1)
`define NES_APB_REGION_BIT  4

// register map, byte addresses
`define NES_REG_GPIO_DIR    8'h00
`define NES_REG_GPIO_OUT    8'h04
`define NES_REG_GPIO_IN     8'h08
`define NES_REG_AUD_SAMPLE  8'h10
`define NES_REG_AUD_CTRL    8'h14
`define NES_REG_AUD_PERIODS 8'h18

`endif

/* verilog/nesPkg.sv */
`include "nes_config.svh"

package nesPkg;

// APB byte address
typedef logic [`NES_APB_ADDR_W-1:0] apbAddrT;

// APB data word
typedef logic [`NES_APB_DATA_W-1:0] apbDataT;

// one bit per GPIO pin
typedef logic [`NES_GPIO_W-1:0] gpioVecT;

// audio sample, also the PWM compare value
typedef logic [`NES_PWM_W-1:0] sampleT;

endpackage

/* verilog/apbIf.sv */
`timescale 1ns/1ps

interface apbIf;

import nesPkg::*;

logic pSel;		// request side, from the decoder
logic pEnable;
logic pWrite;
apbAddrT pAddr;
apbDataT pWdata;

apbDataT pRdata;	// response side, from the peripheral
logic pReady;
logic pSlvErr;

modport master (
	output pSel, pEnable, pWrite, pAddr, pWdata,
	input pRdata, pReady, pSlvErr
);

modport slave (
	input pSel, pEnable, pWrite, pAddr, pWdata,
	output pRdata, pReady, pSlvErr
);

endinterface

/* verilog/apuPwm.sv */
`timescale 1ns/1ps

module apuPwm (
	input logic clk,
	input logic arstN,
	input logic en,
	input nesPkg::sampleT cmp,
	output logic q,
	output logic wrap
);

import nesPkg::*;

sampleT cnt;		// one full sweep is one 256-cycle period

always_ff @(posedge clk, negedge arstN) begin
	if (!arstN)
		cnt <= '0;
	else if (en)
		cnt <= cnt + 1'b1;
	else
		cnt <= '0;	// parked at 0 while disabled
end

// every sweep visits each count once, so high cycles equal cmp
always_ff @(posedge clk, negedge arstN) begin
	if (!arstN) begin
		q <= 1'b0;
		wrap <= 1'b0;
	end else begin
		q <= en & (cnt < cmp);
		wrap <= en & (cnt == '1);	// one pulse as the count rolls over
	end
end

endmodule

/* verilog/apbDecoder.sv */
`timescale 1ns/1ps
`include "nes_config.svh"

module apbDecoder (
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input nesPkg::apbAddrT pAddr,
	input nesPkg::apbDataT pWdata,
	output nesPkg::apbDataT pRdata,
	output logic pReady,
	output logic pSlvErr,

	apbIf.master gpioBus,
	apbIf.master audioBus
);

logic mapped;		// address below 0x20
logic gpioHit, audioHit;
logic access;

assign mapped = pAddr[`NES_APB_ADDR_W-1:`NES_APB_REGION_BIT+1] == '0;
assign gpioHit = mapped & ~pAddr[`NES_APB_REGION_BIT];
assign audioHit = mapped & pAddr[`NES_APB_REGION_BIT];
assign access = pSel & pEnable;

// request fan-out, select only goes to the matching region
assign gpioBus.pSel = pSel & gpioHit;
assign gpioBus.pEnable = pEnable;
assign gpioBus.pWrite = pWrite;
assign gpioBus.pAddr = pAddr;
assign gpioBus.pWdata = pWdata;

assign audioBus.pSel = pSel & audioHit;
assign audioBus.pEnable = pEnable;
assign audioBus.pWrite = pWrite;
assign audioBus.pAddr = pAddr;
assign audioBus.pWdata = pWdata;

// response mux
always_comb begin
	if (gpioHit) begin
		pRdata = gpioBus.pRdata;
		pReady = gpioBus.pReady;
		pSlvErr = gpioBus.pSlvErr;
	end else if (audioHit) begin
		pRdata = audioBus.pRdata;
		pReady = audioBus.pReady;
		pSlvErr = audioBus.pSlvErr;
	end else begin
		// unmapped space, the decoder answers on its own
		pRdata = '0;
		pReady = access;
		pSlvErr = access;
	end
end

endmodule

/* verilog/gpioPort.sv */
`timescale 1ns/1ps
`include "nes_config.svh"

module gpioPort (
	input logic clk,
	input logic arstN,
	input nesPkg::gpioVecT gpioIn,
	output nesPkg::gpioVecT gpioOut,
	output nesPkg::gpioVecT gpioOe,

	apbIf.slave bus
);

import nesPkg::*;

gpioVecT dirReg;		// 1 = pin is an output
gpioVecT outReg;
gpioVecT inMeta, inSync;	// pad synchronizer stages
apbDataT rdData;

logic access;
logic isDir, isOut, isIn;
logic badOffset, roWrite, err;
logic wrEn;

assign access = bus.pSel & bus.pEnable;

// offset decode, full address compared since the region is fixed
assign isDir = bus.pAddr == `NES_REG_GPIO_DIR;
assign isOut = bus.pAddr == `NES_REG_GPIO_OUT;
assign isIn = bus.pAddr == `NES_REG_GPIO_IN;

assign badOffset = ~(isDir | isOut | isIn);
assign roWrite = isIn & bus.pWrite;		// IN is read only
assign err = badOffset | roWrite;
assign wrEn = access & bus.pWrite & ~err;	// failed writes change nothing

always_ff @(posedge clk, negedge arstN) begin
	if (!arstN) begin
		dirReg <= '0;		// all pins start as inputs
		outReg <= '0;
	end else if (wrEn) begin
		if (isDir)
			dirReg <= bus.pWdata;
		if (isOut)
			outReg <= bus.pWdata;
	end
end

// two flops, so a pad change shows up in IN two edges later
always_ff @(posedge clk) begin
	inMeta <= gpioIn;
	inSync <= inMeta;
end

always_comb begin
	rdData = '0;
	if (isDir)
		rdData = dirReg;
	else if (isOut)
		rdData = outReg;
	else if (isIn)
		rdData = inSync & ~dirReg;	// output pins read 0
end

assign bus.pRdata = rdData;
assign bus.pReady = access;		// zero wait states
assign bus.pSlvErr = access & err;

assign gpioOut = outReg;
assign gpioOe = dirReg;

endmodule

/* verilog/audioCtrl.sv */
`timescale 1ns/1ps
`include "nes_config.svh"

module audioCtrl (
	input logic clk,
	input logic arstN,
	output logic pwmOut,

	apbIf.slave bus
);

import nesPkg::*;

sampleT sampleReg;	// current DAC level
logic enReg;		// CTRL bit 0
apbDataT periods;	// DAC wraps, modulo 256
logic dacWrap;
apbDataT rdData;

logic access;
logic isSample, isCtrl, isPeriods;
logic err;
logic wrEn;

assign access = bus.pSel & bus.pEnable;

assign isSample = bus.pAddr == `NES_REG_AUD_SAMPLE;
assign isCtrl = bus.pAddr == `NES_REG_AUD_CTRL;
assign isPeriods = bus.pAddr == `NES_REG_AUD_PERIODS;

assign err = ~(isSample | isCtrl | isPeriods);
assign wrEn = access & bus.pWrite & ~err;

always_ff @(posedge clk, negedge arstN) begin
	if (!arstN) begin
		sampleReg <= '0;
		enReg <= 1'b0;
	end else if (wrEn) begin
		if (isSample)
			sampleReg <= bus.pWdata;
		if (isCtrl)
			enReg <= bus.pWdata[0];
	end
end

// any write clears, and wins over a wrap in the same cycle
always_ff @(posedge clk, negedge arstN) begin
	if (!arstN)
		periods <= '0;
	else if (wrEn & isPeriods)
		periods <= '0;
	else if (dacWrap)
		periods <= periods + 1'b1;
end

always_comb begin
	rdData = '0;
	if (isSample)
		rdData = sampleReg;
	else if (isCtrl)
		rdData = {{(`NES_APB_DATA_W-1){1'b0}}, enReg};	// upper bits read 0
	else if (isPeriods)
		rdData = periods;
end

assign bus.pRdata = rdData;
assign bus.pReady = access;
assign bus.pSlvErr = access & err;

apuPwm pwm0 (
	.clk(clk),
	.arstN(arstN),
	.en(enReg),
	.cmp(sampleReg),
	.q(pwmOut),
	.wrap(dacWrap)
);

endmodule

/* verilog/ioSystem.sv */
`timescale 1ns/1ps

module ioSystem (
	input logic clk,
	input logic arstN,

	// APB from the bus master
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input nesPkg::apbAddrT pAddr,
	input nesPkg::apbDataT pWdata,
	output nesPkg::apbDataT pRdata,
	output logic pReady,
	output logic pSlvErr,

	// GPIO, combined with pad buffers on the board
	input nesPkg::gpioVecT gpioIn,
	output nesPkg::gpioVecT gpioOut,
	output nesPkg::gpioVecT gpioOe,

	// audio DAC
	output logic pwmOut
);

apbIf gpioBus ();
apbIf audioBus ();

apbDecoder dec0 (
	.pSel(pSel),
	.pEnable(pEnable),
	.pWrite(pWrite),
	.pAddr(pAddr),
	.pWdata(pWdata),
	.pRdata(pRdata),
	.pReady(pReady),
	.pSlvErr(pSlvErr),
	.gpioBus(gpioBus.master),
	.audioBus(audioBus.master)
);

gpioPort gpio0 (
	.clk(clk),
	.arstN(arstN),
	.gpioIn(gpioIn),
	.gpioOut(gpioOut),
	.gpioOe(gpioOe),
	.bus(gpioBus.slave)
);

audioCtrl audio0 (
	.clk(clk),
	.arstN(arstN),
	.pwmOut(pwmOut),
	.bus(audioBus.slave)
);

endmodule

/* test/ioSystem_tb.sv */
`timescale 1ns/1ps
`include "nes_config.svh"

module ioSystem_tb;

import nesPkg::*;

localparam int clkPeriod = 100;
localparam int timeoutCycles = 16;	// ready is expected in the first access cycle
localparam int pwmPeriod = 256;

logic clk;
logic arstN;
logic pSel;
logic pEnable;
logic pWrite;
apbAddrT pAddr;
apbDataT pWdata;
apbDataT pRdata;
logic pReady;
logic pSlvErr;
gpioVecT gpioIn;
gpioVecT gpioOut;
gpioVecT gpioOe;
logic pwmOut;

int unsigned cycleCount;
logic [31:0] lcgState;

ioSystem dut_i (
	.clk(clk),
	.arstN(arstN),
	.pSel(pSel),
	.pEnable(pEnable),
	.pWrite(pWrite),
	.pAddr(pAddr),
	.pWdata(pWdata),
	.pRdata(pRdata),
	.pReady(pReady),
	.pSlvErr(pSlvErr),
	.gpioIn(gpioIn),
	.gpioOut(gpioOut),
	.gpioOe(gpioOe),
	.pwmOut(pwmOut)
);

initial clk = 1'b0;
always #(clkPeriod / 2) clk = ~clk;

always @(posedge clk) cycleCount <= cycleCount + 1;	// elapsed-time reference

function automatic logic [7:0] nextRandom();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return lcgState[23:16];	// middle bits since the low ones repeat quickly
endfunction

task automatic stopRun(input string reason);
	$display("%s", reason);
	$display("Test FAILED");
	$fatal(1, "simulation stopped");
endtask

task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		stopRun($sformatf("error at %0t: %s is %0h, expected %0h", $time, name, got, exp));
endtask

// setup cycle then access cycles until ready is seen mid low phase
task automatic busTransfer(input logic wr, input apbAddrT addr, input apbDataT wdata,
		output apbDataT rdata, output logic err);
	int waitCount;
	@(negedge clk);
	pSel = 1'b1;
	pEnable = 1'b0;
	pWrite = wr;
	pAddr = addr;
	pWdata = wdata;
	@(negedge clk);
	pEnable = 1'b1;
	waitCount = 0;
	#(clkPeriod / 4);
	while (!pReady) begin
		if (waitCount >= timeoutCycles)
			stopRun($sformatf("APB transfer to address %h never got ready", addr));
		waitCount++;
		@(negedge clk);
		#(clkPeriod / 4);
	end
	checkValue("pReady wait cycles", waitCount, 0);	// zero wait states
	rdata = pRdata;
	err = pSlvErr;
	@(negedge clk);	// transfer completed at the edge before this
	pSel = 1'b0;
	pEnable = 1'b0;
endtask

task automatic apbWrite(input apbAddrT addr, input apbDataT data, output logic err);
	apbDataT unused;
	busTransfer(1'b1, addr, data, unused, err);
endtask

task automatic apbRead(input apbAddrT addr, output apbDataT data, output logic err);
	busTransfer(1'b0, addr, '0, data, err);
endtask

task automatic setPads(input gpioVecT value);
	@(negedge clk);
	gpioIn = value;
	repeat (3) @(negedge clk);	// past the two synchronizer flops
endtask

task automatic checkDuty(input sampleT sample);
	logic err;
	int highs;
	apbWrite(`NES_REG_AUD_SAMPLE, sample, err);
	checkValue("pSlvErr", err, 0);
	apbWrite(`NES_REG_AUD_CTRL, 8'h01, err);
	checkValue("pSlvErr", err, 0);
	repeat (pwmPeriod) @(negedge clk);	// let the new level settle
	highs = 0;
	repeat (pwmPeriod) begin
		@(negedge clk);
		if (pwmOut)
			highs++;
	end
	checkValue($sformatf("pwmOut high cycles for sample %h", sample), highs, sample);
endtask

task automatic checkPwmOff();
	logic err;
	apbWrite(`NES_REG_AUD_CTRL, 8'h00, err);
	checkValue("pSlvErr", err, 0);
	repeat (pwmPeriod) begin
		@(negedge clk);
		checkValue("pwmOut while disabled", pwmOut, 0);
	end
endtask

task automatic checkPeriods(input int periodsToRun);
	logic err;
	apbDataT count;
	int unsigned startCycle;
	int unsigned elapsed;
	startCycle = cycleCount;
	apbWrite(`NES_REG_AUD_PERIODS, 8'h00, err);	// any write clears
	checkValue("pSlvErr", err, 0);
	apbWrite(`NES_REG_AUD_CTRL, 8'h01, err);
	checkValue("pSlvErr", err, 0);
	for (int i = 0; i < periodsToRun; i++)
		repeat (pwmPeriod) @(negedge clk);
	apbRead(`NES_REG_AUD_PERIODS, count, err);
	checkValue("pSlvErr", err, 0);
	elapsed = cycleCount - startCycle;
	checkValue("PERIODS non-zero", count != 0, 1);
	checkValue("PERIODS within elapsed periods", count <= elapsed / pwmPeriod + 1, 1);
endtask

initial begin
	int fd;
	int n;
	string op;
	string line;
	logic [7:0] a;
	logic [7:0] d;
	apbDataT rd;
	logic err;
	gpioVecT dir;
	gpioVecT pad;

	arstN = 1'b0;
	pSel = 1'b0;
	pEnable = 1'b0;
	pWrite = 1'b0;
	pAddr = '0;
	pWdata = '0;
	gpioIn = '0;
	cycleCount = 0;
	lcgState = 32'd64336;
	repeat (8) @(negedge clk);
	arstN = 1'b1;

	checkValue("gpioOe", gpioOe, 0);
	checkValue("gpioOut", gpioOut, 0);
	checkValue("pwmOut", pwmOut, 0);
	checkValue("pReady", pReady, 0);
	checkValue("pSlvErr", pSlvErr, 0);

	fd = $fopen("test/ioSystem_vectors.txt", "r");
	if (fd == 0)
		stopRun("cannot open test/ioSystem_vectors.txt");
	while (!$feof(fd)) begin
		n = $fscanf(fd, "%s", op);
		if (n != 1)
			break;
		if (op.substr(0, 0) == "#") begin
			n = $fgets(line, fd);	// skip the rest of a comment line
		end else begin
			n = $fscanf(fd, "%h %h", a, d);
			if (n != 2)
				stopRun($sformatf("vector line for operation %s is missing a field", op));
			if (op == "W") begin
				apbWrite(a, d, err);
				checkValue("pSlvErr", err, 0);
			end else if (op == "R") begin
				apbRead(a, rd, err);
				checkValue("pSlvErr", err, 0);
				checkValue($sformatf("pRdata at %h", a), rd, d);
			end else if (op == "X") begin
				apbWrite(a, d, err);
				checkValue($sformatf("pSlvErr on write to %h", a), err, 1);
			end else if (op == "Y") begin
				apbRead(a, rd, err);
				checkValue($sformatf("pSlvErr on read of %h", a), err, 1);
			end else if (op == "G") begin
				setPads(d);
			end else if (op == "O") begin
				checkValue("gpioOe", gpioOe, a);
				checkValue("gpioOut", gpioOut, d);
			end else if (op == "D") begin
				checkDuty(d);
			end else if (op == "Q") begin
				checkPwmOff();
			end else if (op == "P") begin
				checkPeriods(d);
			end else begin
				stopRun($sformatf("unknown vector operation %s", op));
			end
		end
	end
	$fclose(fd);

	// IN must read random pads masked by a random ~DIR
	for (int i = 0; i < 8; i++) begin
		dir = nextRandom();
		pad = nextRandom();
		apbWrite(`NES_REG_GPIO_DIR, dir, err);
		checkValue("pSlvErr", err, 0);
		setPads(pad);
		checkValue("gpioOe", gpioOe, dir);
		apbRead(`NES_REG_GPIO_IN, rd, err);
		checkValue("pSlvErr", err, 0);
		checkValue("GPIO IN", rd, pad & ~dir);
	end
	apbWrite(`NES_REG_GPIO_DIR, 8'h00, err);
	checkValue("pSlvErr", err, 0);

	for (int i = 0; i < 3; i++)
		checkDuty(nextRandom());
	checkPwmOff();

	$display("Test OK");
	$finish;
end

endmodule

/* vlog.f */
+incdir+include
verilog/nesPkg.sv
verilog/apbIf.sv
verilog/apuPwm.sv
verilog/apbDecoder.sv
verilog/gpioPort.sv
verilog/audioCtrl.sv
verilog/ioSystem.sv
test/ioSystem_tb.sv

/* test/ioSystem_vectors.txt */
# columns: op addr data, both hex
# W write, R read and expect data, X write expecting error, Y read expecting error,
# G set pads to data, O expect gpioOe=addr gpioOut=data, D duty of sample data,
# Q PWM off check, P run data periods and check PERIODS
R 00 00
R 04 00
R 08 00
R 10 00
R 14 00
R 18 00
W 00 f0
W 04 a5
O f0 a5
R 00 f0
R 04 a5
W 00 3c
W 04 81
O 3c 81
R 00 3c
R 04 81
G 00 ff
R 08 c3
G 00 5a
R 08 42
W 00 00
R 08 5a
# bus errors, registers must stay unchanged
X 20 55
Y 40 00
X 08 77
R 08 5a
X 0c 99
Y 1c 00
X 1c 11
R 00 00
R 04 81
X 80 ff
R 10 00
# audio
W 10 40
R 10 40
W 14 ff
R 14 01
D 00 40
D 00 01
D 00 ff
D 00 00
D 00 80
Q 00 00
P 00 03
W 14 00
W 18 00
R 18 00
O 00 81
